// ==== verilog/ctu_clk_pkg.sv ====
// Clock-control package with clock modes, front-end states and select-vector layout
package ctu_clk_pkg;

   // --------------------
   // Command encodings
   // --------------------

   // Requested clock mode, as carried on the command port
   typedef enum logic [1:0] {
      mode_sys   = 2'd0,
      mode_byp   = 2'd1,
      mode_tck   = 2'd2,
      mode_nstep = 2'd3
   } clk_mode_e;

   // Command front-end FSM states
   typedef enum logic [1:0] {
      st_idle   = 2'd0,
      st_settle = 2'd1,
      st_nstep  = 2'd2
   } ctl_state_e;

   // --------------------
   // Select vector
   // --------------------

   // Registered on sysclk, resynchronized per destination clock in the selector
   typedef logic [2:0] clk_sel_t;

   // Bit positions within clk_sel_t
   localparam int unsigned SEL_FORCE_ALT = 0;
   localparam int unsigned SEL_TCK_EN    = 1;
   localparam int unsigned SEL_BYP_EN    = 2;

endpackage

// ==== verilog/clk_sel_if.sv ====
// Decoded clock-select controls passed from the command front end to the clock selector
`timescale 1ns/1ps

interface clk_sel_if
   import ctu_clk_pkg::*;
();
   // Enable bits, see SEL_* positions in the package
   clk_sel_t sel_vec;
   // Low while bypass or N-step owns the output
   logic     byp_mult_sel_l;
   // Bypass mode flag
   logic     bypmode;
   // N-step capture mode flag
   logic     nstepsel;
   // Low passes the raw JTAG clock, high gates it with the capture window
   logic     testmode_l;

   // Front end drives all controls from sysclk flops
   modport ctl (output sel_vec, output byp_mult_sel_l, output bypmode,
                output nstepsel, output testmode_l);

   // Clock selector only reads them
   modport sel (input sel_vec, input byp_mult_sel_l, input bypmode,
                input nstepsel, input testmode_l);

endinterface

// ==== verilog/ctu_clksel_sync.sv ====
// Two-flop synchronizer with asynchronous reset to a selectable level
`timescale 1ns/1ps

module ctu_clksel_sync #(
   // Level forced by reset, 1 for active-low lines
   parameter logic RST_VAL = 1'b0
) (
   input  logic clk,
   input  logic rst_n,
   input  logic din,
   output logic dout
);

   // First stage, may go metastable
   logic meta_q;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         meta_q <= RST_VAL;
         dout   <= RST_VAL;
      end else begin
         // Second stage resolves the first
         meta_q <= din;
         dout   <= meta_q;
      end
   end

endmodule

// ==== verilog/ctu_clksel.sv ====
// Clock selector that synchronizes select bits per clock and gates the output clock
`timescale 1ns/1ps

module ctu_clksel
   import ctu_clk_pkg::*;
(
   input  logic   rst_n,
   input  logic   sysclk,
   input  logic   divbypclk,
   input  logic   jtag_clock_dr,
   input  logic   capture_l,
   clk_sel_if.sel ctl,
   output logic   clkout,
   output logic   sysclk_sel
);

   // Force-alternate product of sel bit 0 and the alternate-mode flags
   logic force_alt;
   // Synchronized copies, one per destination clock
   logic force_alt_clk_sync;
   logic altclk_sync_l;
   logic bypclk_sync;
   logic tck_sync;
   // JTAG path
   logic nstep_clock_dr;
   logic clock_dr;

   assign force_alt = ctl.sel_vec[SEL_FORCE_ALT] & (ctl.bypmode | ctl.nstepsel);

   // --------------------
   // Synchronizers
   // --------------------

   // Force-alternate term into sysclk
   ctu_clksel_sync #(.RST_VAL(1'b0)) u_force_alt_sync (
      .clk   (sysclk),
      .rst_n (rst_n),
      .din   (force_alt),
      .dout  (force_alt_clk_sync)
   );

   // Active-low select, so it resets high
   ctu_clksel_sync #(.RST_VAL(1'b1)) u_byp_mult_sel_sync (
      .clk   (divbypclk),
      .rst_n (rst_n),
      .din   (ctl.byp_mult_sel_l),
      .dout  (altclk_sync_l)
   );

   // Bypass enable in its own clock
   ctu_clksel_sync #(.RST_VAL(1'b0)) u_bypclk_sync (
      .clk   (divbypclk),
      .rst_n (rst_n),
      .din   (ctl.sel_vec[SEL_BYP_EN]),
      .dout  (bypclk_sync)
   );

   // JTAG enable in the JTAG clock
   ctu_clksel_sync #(.RST_VAL(1'b0)) u_tck_sync (
      .clk   (jtag_clock_dr),
      .rst_n (rst_n),
      .din   (ctl.sel_vec[SEL_TCK_EN]),
      .dout  (tck_sync)
   );

   // --------------------
   // Clock gating
   // --------------------

   // Capture window opens and closes on falling JTAG edges, so pulses stay whole
   assign nstep_clock_dr = jtag_clock_dr & capture_l;
   // Test mode takes the raw JTAG clock
   assign clock_dr = ctl.testmode_l ? nstep_clock_dr : jtag_clock_dr;

   // AND-OR-invert of the two enabled clocks
   assign clkout = ~((bypclk_sync & divbypclk) | (tck_sync & clock_dr));

   // Alternate clock in force
   assign sysclk_sel = ~altclk_sync_l | force_alt_clk_sync;

endmodule

// ==== verilog/clk_mode_ctl.sv ====
// Command front end that accepts mode requests, decodes them and waits for settle and N-step
`timescale 1ns/1ps

module clk_mode_ctl
   import ctu_clk_pkg::*;
#(
   parameter int NSTEP_W       = 8,
   parameter int SETTLE_CYCLES = 12
) (
   input  logic               sysclk,
   input  logic               rst_n,
   input  logic               cmd_valid,
   output logic               cmd_ready,
   input  clk_mode_e          cmd_mode,
   input  logic [NSTEP_W-1:0] cmd_nstep,
   clk_sel_if.ctl             ctl,
   output logic               nstep_start,
   output logic [NSTEP_W-1:0] nstep_count,
   input  logic               nstep_done
);

   // Counter holds SETTLE_CYCLES-1 down to zero
   localparam int SETTLE_W = (SETTLE_CYCLES > 1) ? $clog2(SETTLE_CYCLES) : 1;

   ctl_state_e          state;
   logic [SETTLE_W-1:0] settle_cnt;
   logic                cmd_xfer;
   logic                done_sync;
   // Decoded controls for the pending command
   clk_sel_t            dec_sel;
   logic                dec_byp_mult_sel_l;
   logic                dec_testmode_l;
   logic                dec_bypmode;
   logic                dec_nstepsel;

   assign cmd_xfer = cmd_valid & cmd_ready;

   // Done comes from the JTAG domain
   ctu_clksel_sync #(.RST_VAL(1'b0)) u_done_sync (
      .clk   (sysclk),
      .rst_n (rst_n),
      .din   (nstep_done),
      .dout  (done_sync)
   );

   // --------------------
   // Mode decode
   // --------------------
   always_comb begin
      // System clock values
      dec_sel            = '0;
      dec_byp_mult_sel_l = 1'b1;
      dec_testmode_l     = 1'b1;
      dec_bypmode        = 1'b0;
      dec_nstepsel       = 1'b0;
      case (cmd_mode)
         mode_byp: begin
            dec_sel[SEL_BYP_EN] = 1'b1;
            dec_byp_mult_sel_l  = 1'b0;
            dec_bypmode         = 1'b1;
         end
         mode_tck: begin
            dec_sel[SEL_TCK_EN] = 1'b1;
            dec_testmode_l      = 1'b0;
         end
         mode_nstep: begin
            // JTAG clock gated by the capture window
            dec_sel[SEL_TCK_EN]    = 1'b1;
            dec_sel[SEL_FORCE_ALT] = 1'b1;
            dec_byp_mult_sel_l     = 1'b0;
            dec_nstepsel           = 1'b1;
         end
         // mode_sys keeps the defaults
         default: ;
      endcase
   end

   // --------------------
   // Control FSM
   // --------------------
   always_ff @(posedge sysclk or negedge rst_n) begin
      if (!rst_n) begin
         state              <= st_idle;
         cmd_ready          <= 1'b0;
         settle_cnt         <= '0;
         nstep_start        <= 1'b0;
         ctl.sel_vec        <= '0;
         ctl.byp_mult_sel_l <= 1'b1;
         ctl.testmode_l     <= 1'b1;
         ctl.bypmode        <= 1'b0;
         ctl.nstepsel       <= 1'b0;
      end else begin
         case (state)
            st_idle: begin
               // First edge after reset raises ready
               cmd_ready <= 1'b1;
               if (cmd_xfer) begin
                  cmd_ready          <= 1'b0;
                  ctl.sel_vec        <= dec_sel;
                  ctl.byp_mult_sel_l <= dec_byp_mult_sel_l;
                  ctl.testmode_l     <= dec_testmode_l;
                  ctl.bypmode        <= dec_bypmode;
                  ctl.nstepsel       <= dec_nstepsel;
                  settle_cnt         <= SETTLE_W'(SETTLE_CYCLES - 1);
                  state              <= st_settle;
               end
            end
            st_settle: begin
               if (settle_cnt != '0) begin
                  settle_cnt <= settle_cnt - 1'b1;
               end else if (!ctl.nstepsel) begin
                  cmd_ready <= 1'b1;
                  state     <= st_idle;
               end else if (!done_sync) begin
                  // Previous burst has fully retired
                  nstep_start <= 1'b1;
                  state       <= st_nstep;
               end
            end
            st_nstep: begin
               // Hold start until the burst reports done
               if (done_sync) begin
                  nstep_start <= 1'b0;
                  cmd_ready   <= 1'b1;
                  state       <= st_idle;
               end
            end
            default: state <= st_idle;
         endcase
      end
   end

   // Pulse count, stable while start is high
   always_ff @(posedge sysclk) begin
      if (cmd_xfer) begin
         nstep_count <= cmd_nstep;
      end
   end

endmodule

// ==== verilog/nstep_capture.sv ====
// N-step capture counter that opens the JTAG clock window for a set number of pulses
`timescale 1ns/1ps

module nstep_capture #(
   parameter int NSTEP_W = 8
) (
   input  logic               jtag_clock_dr,
   input  logic               rst_n,
   input  logic               nstep_start,
   input  logic [NSTEP_W-1:0] nstep_count,
   output logic               capture_l,
   output logic               nstep_done
);

   logic               start_sync;
   // Pulses still to release
   logic [NSTEP_W-1:0] pulse_cnt;

   // Start is a sysclk level
   ctu_clksel_sync #(.RST_VAL(1'b0)) u_start_sync (
      .clk   (jtag_clock_dr),
      .rst_n (rst_n),
      .din   (nstep_start),
      .dout  (start_sync)
   );

   // --------------------
   // Window control
   // --------------------
   // Falling edges only, so the window never cuts a high phase
   always_ff @(negedge jtag_clock_dr or negedge rst_n) begin
      if (!rst_n) begin
         capture_l  <= 1'b0;
         nstep_done <= 1'b0;
         pulse_cnt  <= '0;
      end else if (!start_sync) begin
         // Start dropped, rearm for the next burst
         capture_l  <= 1'b0;
         nstep_done <= 1'b0;
      end else if (capture_l) begin
         // One whole pulse passed since the last falling edge
         pulse_cnt <= pulse_cnt - 1'b1;
         if (pulse_cnt == NSTEP_W'(1)) begin
            capture_l  <= 1'b0;
            nstep_done <= 1'b1;
         end
      end else if (!nstep_done) begin
         // Load and open the window
         pulse_cnt <= nstep_count;
         if (nstep_count == '0) begin
            nstep_done <= 1'b1;
         end else begin
            capture_l <= 1'b1;
         end
      end
   end

endmodule

// ==== verilog/ctu_clkgn_top.sv ====
// Clock-select top joining the command front end, N-step counter and clock selector
`timescale 1ns/1ps

module ctu_clkgn_top
   import ctu_clk_pkg::*;
#(
   parameter int NSTEP_W       = 8,
   parameter int SETTLE_CYCLES = 12
) (
   input  logic               sysclk,
   input  logic               divbypclk,
   input  logic               jtag_clock_dr,
   input  logic               rst_n,
   input  logic               cmd_valid,
   input  clk_mode_e          cmd_mode,
   input  logic [NSTEP_W-1:0] cmd_nstep,
   output logic               cmd_ready,
   output logic               clkout,
   output logic               sysclk_sel
);

   // N-step handshake across sysclk and JTAG clock
   logic               nstep_start;
   logic [NSTEP_W-1:0] nstep_count;
   logic               nstep_done;
   // Capture window into the selector
   logic               capture_l;

   // Decoded select controls
   clk_sel_if u_sel_if ();

   // --------------------
   // sysclk domain
   // --------------------
   clk_mode_ctl #(
      .NSTEP_W       (NSTEP_W),
      .SETTLE_CYCLES (SETTLE_CYCLES)
   ) u_clk_mode_ctl (
      .sysclk      (sysclk),
      .rst_n       (rst_n),
      .cmd_valid   (cmd_valid),
      .cmd_ready   (cmd_ready),
      .cmd_mode    (cmd_mode),
      .cmd_nstep   (cmd_nstep),
      .ctl         (u_sel_if.ctl),
      .nstep_start (nstep_start),
      .nstep_count (nstep_count),
      .nstep_done  (nstep_done)
   );

   // --------------------
   // JTAG domain
   // --------------------
   nstep_capture #(
      .NSTEP_W (NSTEP_W)
   ) u_nstep_capture (
      .jtag_clock_dr (jtag_clock_dr),
      .rst_n         (rst_n),
      .nstep_start   (nstep_start),
      .nstep_count   (nstep_count),
      .capture_l     (capture_l),
      .nstep_done    (nstep_done)
   );

   // Output clock mux
   ctu_clksel u_clksel (
      .rst_n         (rst_n),
      .sysclk        (sysclk),
      .divbypclk     (divbypclk),
      .jtag_clock_dr (jtag_clock_dr),
      .capture_l     (capture_l),
      .ctl           (u_sel_if.sel),
      .clkout        (clkout),
      .sysclk_sel    (sysclk_sel)
   );

endmodule

// ==== bench/tb_clkgen.sv ====
// Testbench clock and reset source for sysclk, the bypass clock and the JTAG clock
`timescale 1ns/1ps

module tb_clkgen #(
   parameter int SYS_HALF     = 20,
   parameter int BYP_HALF     = 50,
   parameter int JTAG_HALF    = 70,
   parameter int RESET_CYCLES = 16
) (
   output logic sysclk,
   output logic divbypclk,
   output logic jtag_clock_dr,
   output logic rst_n
);

   // sysclk edges fall on multiples of 20 ns
   initial begin
      sysclk = 1'b0;
      forever #(SYS_HALF) sysclk = ~sysclk;
   end

   // Offset of 5 ns keeps bypass edges off the sysclk grid
   initial begin
      divbypclk = 1'b0;
      #5;
      forever #(BYP_HALF) divbypclk = ~divbypclk;
   end

   // JTAG edges end in 7 ns, away from both other clocks
   initial begin
      jtag_clock_dr = 1'b0;
      #7;
      forever #(JTAG_HALF) jtag_clock_dr = ~jtag_clock_dr;
   end

   // Release lands between sysclk edges
   initial begin
      rst_n = 1'b0;
      #(RESET_CYCLES * 2 * SYS_HALF + 10);
      rst_n = 1'b1;
   end

endmodule

// ==== bench/tb_checker.sv ====
// Testbench checker that follows each command and compares the DUT outputs with a reference
`timescale 1ns/1ps

module tb_checker
   import ctu_clk_pkg::*;
#(
   parameter int NSTEP_W       = 8,
   parameter int SETTLE_CYCLES = 12
) (
   input  logic               sysclk,
   input  logic               divbypclk,
   input  logic               jtag_clock_dr,
   input  logic               rst_n,
   input  logic               cmd_valid,
   input  clk_mode_e          cmd_mode,
   input  logic [NSTEP_W-1:0] cmd_nstep,
   input  logic               cmd_ready,
   input  logic               clkout,
   input  logic               sysclk_sel,
   output int                 tests_done,
   output int                 checks,
   output int                 errors
);

   // Ready low this long means the front end hung
   localparam int READY_LIMIT = SETTLE_CYCLES + 200;
   // Output samples per steady-state window
   localparam int WINDOW      = 4;

   // --------------------
   // Transfer tracking
   // --------------------
   int        xfer_cnt = 0;
   logic      busy = 1'b0;
   int        low_cnt;
   clk_mode_e cur_mode;
   int        cur_n;
   int        falls_start;
   // Mismatch seen at the end of settle for the current command
   int        settle_err;
   logic [1:0] settle_exp;
   // Free-running count of clkout falling edges
   int        clk_falls = 0;
   // Finished commands, oldest first
   clk_mode_e res_mode_q[$];
   int        res_n_q[$];
   int        res_low_q[$];
   int        res_pulse_q[$];
   int        res_settle_q[$];
   // Errors of the test being compared
   int        test_err;

   always @(negedge clkout) begin
      clk_falls++;
   end

   // Values read here are the ones the DUT flops see on this edge
   always @(posedge sysclk) begin
      if (busy) begin
         if (cmd_ready || low_cnt >= READY_LIMIT) begin
            res_mode_q.push_back(cur_mode);
            res_n_q.push_back(cur_n);
            res_low_q.push_back(low_cnt);
            res_pulse_q.push_back(clk_falls - falls_start);
            res_settle_q.push_back(settle_err);
            busy = 1'b0;
         end else begin
            low_cnt++;
            // Burst can only start once settle is over
            if (low_cnt == SETTLE_CYCLES) begin
               falls_start = clk_falls;
               // Mode is in force here, even with the next command already held
               if (cur_mode != mode_nstep) begin
                  settle_exp = ref_outputs(cur_mode, divbypclk, jtag_clock_dr, 1'b0);
                  if ({clkout, sysclk_sel} !== settle_exp) begin
                     $display("** Error at %0d ns: %s settle end, got %b %b, expected %b %b",
                              $time, cur_mode.name(), clkout, sysclk_sel,
                              settle_exp[1], settle_exp[0]);
                     settle_err = 1;
                  end
               end
            end
         end
      end
      // A held command may transfer on the edge that ends the last one
      if (cmd_valid && cmd_ready) begin
         xfer_cnt++;
         busy        = 1'b1;
         low_cnt     = 0;
         cur_mode    = cmd_mode;
         cur_n       = int'(cmd_nstep);
         falls_start = clk_falls;
         settle_err  = 0;
      end
   end

   // --------------------
   // Reference model
   // --------------------
   // Expected {clkout, sysclk_sel} from the decode table and the output rule
   function automatic logic [1:0] ref_outputs(input clk_mode_e mode, input logic byp_clk,
                                              input logic tck, input logic capture);
      logic byp_en;
      logic tck_en;
      logic force_alt;
      logic mult_sel_l;
      logic testmode_l;
      logic alt_req;
      logic jtag_path;
      byp_en     = (mode == mode_byp);
      tck_en     = (mode == mode_tck) || (mode == mode_nstep);
      force_alt  = (mode == mode_nstep);
      mult_sel_l = !((mode == mode_byp) || (mode == mode_nstep));
      testmode_l = (mode != mode_tck);
      alt_req    = (mode == mode_byp) || (mode == mode_nstep);
      // Capture window only gates the JTAG path outside test mode
      jtag_path  = testmode_l ? (tck & capture) : tck;
      return {~((byp_en & byp_clk) | (tck_en & jtag_path)), ~mult_sel_l | (force_alt & alt_req)};
   endfunction

   // Samples 10 ns after the source clock edges until a newer command shows up
   task automatic steady_window(input clk_mode_e mode, input int xfer_idx);
      logic [1:0] expected;
      for (int i = 0; i < WINDOW; i++) begin
         if (mode == mode_byp) begin
            @(divbypclk);
         end else begin
            @(jtag_clock_dr);
         end
         #10;
         if (!cmd_ready || xfer_cnt != xfer_idx) begin
            break;
         end
         // Window is closed once ready is back
         expected = ref_outputs(mode, divbypclk, jtag_clock_dr, 1'b0);
         checks++;
         if ({clkout, sysclk_sel} !== expected) begin
            $display("** Error at %0d ns: mode %s clkout %b sysclk_sel %b, expected %b %b",
                     $time, mode.name(), clkout, sysclk_sel, expected[1], expected[0]);
            test_err++;
         end
      end
   endtask

   // --------------------
   // Compare process
   // --------------------
   initial begin : compare
      int        idx;
      clk_mode_e mode;
      int        n;
      int        low;
      int        pulses;
      int        settle_bad;
      bit        ready_seen;
      tests_done = 0;
      checks     = 0;
      errors     = 0;
      ready_seen = 1'b0;
      test_err   = 0;
      wait (rst_n === 1'b1);
      // Ready is due on the first edge after release
      for (int i = 0; i < 4 && !ready_seen; i++) begin
         @(posedge sysclk);
         #1;
         ready_seen = cmd_ready;
      end
      if (!ready_seen) begin
         $display("Test 0 reset: cmd_ready did not rise after reset release");
         test_err++;
      end else begin
         steady_window(mode_sys, 0);
      end
      errors += test_err;
      tests_done++;
      $display("Test 0 reset: %s", (test_err == 0) ? "ok" : "mismatch");

      forever begin
         wait (res_mode_q.size() > 0);
         idx        = tests_done;
         mode       = res_mode_q.pop_front();
         n          = res_n_q.pop_front();
         low        = res_low_q.pop_front();
         pulses     = res_pulse_q.pop_front();
         settle_bad = res_settle_q.pop_front();
         test_err   = 0;
         if (mode != mode_nstep) begin
            checks++;
            test_err += settle_bad;
         end
         if (low >= READY_LIMIT) begin
            $display("Test %0d %s: cmd_ready did not return after the command",
                     idx, mode.name());
            test_err++;
         end else begin
            if (mode != mode_nstep && low != SETTLE_CYCLES) begin
               $display("** Error at %0d ns: cmd_ready low %0d cycles, expected %0d",
                        $time, low, SETTLE_CYCLES);
               test_err++;
            end
            if (mode == mode_nstep && low <= SETTLE_CYCLES) begin
               $display("** Error at %0d ns: N-step ready back after %0d cycles, before the burst",
                        $time, low);
               test_err++;
            end
            if (mode == mode_nstep && pulses != n) begin
               $display("** Error at %0d ns: %0d clkout pulses, expected %0d", $time, pulses, n);
               test_err++;
            end
            steady_window(mode, idx);
         end
         errors += test_err;
         tests_done++;
         $display("Test %0d %s n %0d: ready low %0d, pulses %0d, %s", idx, mode.name(), n,
                  low, pulses, (test_err == 0) ? "ok" : "mismatch");
      end
   end

endmodule

// ==== bench/tb_ctu_clkgn.sv ====
// Testbench top driving directed, back-to-back and random clock-mode commands
`timescale 1ns/1ps

module tb_ctu_clkgn
   import ctu_clk_pkg::*;
();

   localparam int NSTEP_W       = 8;
   localparam int SETTLE_CYCLES = 12;
   localparam int SYS_PERIOD    = 40;
   localparam int JTAG_PERIOD   = 140;
   localparam int NUM_RANDOM    = 40;
   // Reset, five directed, four back to back, then the random run
   localparam int NUM_TESTS     = 1 + 5 + 4 + NUM_RANDOM;
   // Settle, longest burst, and margin for sync and check windows
   localparam int WORST_NS      = SETTLE_CYCLES * SYS_PERIOD + 20 * JTAG_PERIOD + 2000;
   localparam int WATCHDOG_NS   = 16 * SYS_PERIOD + NUM_TESTS * WORST_NS;

   logic               sysclk;
   logic               divbypclk;
   logic               jtag_clock_dr;
   logic               rst_n;
   logic               cmd_valid;
   clk_mode_e          cmd_mode;
   logic [NSTEP_W-1:0] cmd_nstep;
   logic               cmd_ready;
   logic               clkout;
   logic               sysclk_sel;
   int                 tests_done;
   int                 checks;
   int                 errors;
   // Commands taken by the DUT so far
   int                 sent;
   logic [31:0]        rnd_state;

   tb_clkgen #(
      .SYS_HALF  (SYS_PERIOD / 2),
      .BYP_HALF  (50),
      .JTAG_HALF (JTAG_PERIOD / 2)
   ) tb_clkgen_i (
      .sysclk        (sysclk),
      .divbypclk     (divbypclk),
      .jtag_clock_dr (jtag_clock_dr),
      .rst_n         (rst_n)
   );

   ctu_clkgn_top #(
      .NSTEP_W       (NSTEP_W),
      .SETTLE_CYCLES (SETTLE_CYCLES)
   ) ctu_clkgn_top_i (
      .sysclk        (sysclk),
      .divbypclk     (divbypclk),
      .jtag_clock_dr (jtag_clock_dr),
      .rst_n         (rst_n),
      .cmd_valid     (cmd_valid),
      .cmd_mode      (cmd_mode),
      .cmd_nstep     (cmd_nstep),
      .cmd_ready     (cmd_ready),
      .clkout        (clkout),
      .sysclk_sel    (sysclk_sel)
   );

   tb_checker #(
      .NSTEP_W       (NSTEP_W),
      .SETTLE_CYCLES (SETTLE_CYCLES)
   ) tb_checker_i (
      .sysclk        (sysclk),
      .divbypclk     (divbypclk),
      .jtag_clock_dr (jtag_clock_dr),
      .rst_n         (rst_n),
      .cmd_valid     (cmd_valid),
      .cmd_mode      (cmd_mode),
      .cmd_nstep     (cmd_nstep),
      .cmd_ready     (cmd_ready),
      .clkout        (clkout),
      .sysclk_sel    (sysclk_sel),
      .tests_done    (tests_done),
      .checks        (checks),
      .errors        (errors)
   );

   // --------------------
   // Stimulus helpers
   // --------------------
   function automatic logic [31:0] xorshift32(input logic [31:0] state);
      logic [31:0] x;
      x = state;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // Presents a command on a falling edge, returns after the edge that takes it
   task automatic issue_cmd(input clk_mode_e mode, input int n);
      @(negedge sysclk);
      cmd_valid = 1'b1;
      cmd_mode  = mode;
      cmd_nstep = NSTEP_W'(n);
      do begin
         @(posedge sysclk);
      end while (!cmd_ready);
      sent++;
   endtask

   task automatic release_cmd();
      @(negedge sysclk);
      cmd_valid = 1'b0;
   endtask

   // Checker has finished every command sent, reset test included
   task automatic wait_checked();
      wait (tests_done == sent + 1);
   endtask

   task automatic run_cmd(input clk_mode_e mode, input int n);
      issue_cmd(mode, n);
      release_cmd();
      wait_checked();
   endtask

   initial begin : stimulus
      clk_mode_e mode;
      int        n;
      cmd_valid = 1'b0;
      cmd_mode  = mode_sys;
      cmd_nstep = '0;
      sent      = 0;
      rnd_state = 32'h5416;
      wait (tests_done == 1);

      // One of each mode
      run_cmd(mode_byp, 0);
      run_cmd(mode_tck, 0);
      run_cmd(mode_nstep, 5);
      run_cmd(mode_sys, 0);
      run_cmd(mode_nstep, 1);

      // Back to back, each held through the busy time of the last
      issue_cmd(mode_tck, 0);
      issue_cmd(mode_byp, 0);
      issue_cmd(mode_nstep, 3);
      issue_cmd(mode_sys, 0);
      release_cmd();
      wait_checked();

      // Random modes, N from 1 to 20
      for (int i = 0; i < NUM_RANDOM; i++) begin
         rnd_state = xorshift32(rnd_state);
         mode      = clk_mode_e'(rnd_state[1:0]);
         rnd_state = xorshift32(rnd_state);
         n         = int'(rnd_state % 32'd20) + 1;
         run_cmd(mode, n);
      end

      $display("Tests %0d, checks %0d, errors %0d", tests_done, checks, errors);
      if (errors == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

   initial begin : watchdog
      #(WATCHDOG_NS);
      $display("Watchdog timeout: the run did not finish within %0d ns", WATCHDOG_NS);
      $display("Checks failed");
      $finish;
   end

endmodule

// ==== compile.f ====
verilog/ctu_clk_pkg.sv
verilog/clk_sel_if.sv
verilog/ctu_clksel_sync.sv
verilog/ctu_clksel.sv
verilog/clk_mode_ctl.sv
verilog/nstep_capture.sv
verilog/ctu_clkgn_top.sv
bench/tb_clkgen.sv
bench/tb_checker.sv
bench/tb_ctu_clkgn.sv

// ==== Bender.yml ====
package:
  name: ctu_clkgn

sources:
  - files:
      - verilog/ctu_clk_pkg.sv
      - verilog/clk_sel_if.sv
      - verilog/ctu_clksel_sync.sv
      - verilog/ctu_clksel.sv
      - verilog/clk_mode_ctl.sv
      - verilog/nstep_capture.sv
      - verilog/ctu_clkgn_top.sv
  - target: test
    files:
      - bench/tb_clkgen.sv
      - bench/tb_checker.sv
      - bench/tb_ctu_clkgn.sv
